//--- banked_regfile_top.f
design/regbank_pkg.sv
design/bank_addr_decode.sv
design/phys_reg_array.sv
design/write_port_arbiter.sv
design/wb_debug_slave.sv
design/banked_regfile_top.sv
verification/tb_clock_gen.sv
verification/banked_regfile_tb.sv

//--- design/bank_addr_decode.sv
`timescale 1ns/1ns

module bank_addr_decode (
  input  regbank_pkg::cpu_mode_e               mode,
  input  logic                                 swi,
  input  logic [2:0]                           rz_flags,  // {wa3, ra2, ra1}
  input  logic [regbank_pkg::ARCH_AW-1:0]      ra1,
  input  logic [regbank_pkg::ARCH_AW-1:0]      ra2,
  input  logic [regbank_pkg::ARCH_AW-1:0]      wa3,
  output logic [regbank_pkg::NUM_PHYS-1:0]     sel1,
  output logic [regbank_pkg::NUM_PHYS-1:0]     sel2,
  output logic [regbank_pkg::NUM_PHYS-1:0]     sel3
);

  regbank_pkg::cpu_mode_e eff_mode;

  // SWI takes the core into SVC before the mode bits catch up
  assign eff_mode = swi ? regbank_pkg::SVC : mode;

  // One port of the decode, shared by all three
  function automatic logic [regbank_pkg::NUM_PHYS-1:0] decode_port(
    input logic                            rz,
    input logic [regbank_pkg::ARCH_AW-1:0] addr,
    input regbank_pkg::cpu_mode_e          md
  );
    logic [regbank_pkg::NUM_PHYS-1:0] sel;
    logic [regbank_pkg::PHYS_AW-1:0]  idx;
    logic                             hit;
    logic                             r14;
    sel = '0;
    idx = '0;
    hit = 1'b0;
    r14 = (addr == regbank_pkg::ARCH_R14); // Second reg of a bank pair

    if (rz) begin
      // Micro-op shadow, only via address 15
      if (addr == regbank_pkg::RZ_ARCH) begin
        hit = 1'b1;
        idx = regbank_pkg::RZ_PHYS;
      end
    end else if (addr < regbank_pkg::ARCH_R8 || addr == 4'd15) begin
      hit = 1'b1;                                  // R0..R7, PC shared
      idx = regbank_pkg::PHYS_AW'(addr);
    end else if (addr <= regbank_pkg::ARCH_R12) begin
      hit = 1'b1;
      if (md == regbank_pkg::FIQ)
        idx = regbank_pkg::FIQ_BANK + regbank_pkg::PHYS_AW'(addr[2:0]); // R8 -> 24
      else
        idx = regbank_pkg::PHYS_AW'(addr);
    end else begin
      // R13/R14, banked per mode
      hit = 1'b1;
      case (md)
        regbank_pkg::USR,
        regbank_pkg::SYS: idx = regbank_pkg::PHYS_AW'(addr);
        regbank_pkg::SVC: idx = regbank_pkg::SVC_BANK + regbank_pkg::PHYS_AW'(r14);
        regbank_pkg::ABT: idx = regbank_pkg::ABT_BANK + regbank_pkg::PHYS_AW'(r14);
        regbank_pkg::UND: idx = regbank_pkg::UND_BANK + regbank_pkg::PHYS_AW'(r14);
        regbank_pkg::IRQ: idx = regbank_pkg::IRQ_BANK + regbank_pkg::PHYS_AW'(r14);
        // R13 low bits 5, R14 low bits 6, lands on 29/30
        regbank_pkg::FIQ: idx = regbank_pkg::FIQ_BANK + regbank_pkg::PHYS_AW'(addr[2:0]);
        default:          hit = 1'b0;              // Bad mode, no target
      endcase
    end

    if (hit)
      sel[idx] = 1'b1;
    return sel;
  endfunction

  // Read port 1
  always_comb begin
    sel1 = decode_port(rz_flags[0], ra1, eff_mode);
  end

  // Read port 2
  always_comb begin
    sel2 = decode_port(rz_flags[1], ra2, eff_mode);
  end

  // Write port
  always_comb begin
    sel3 = decode_port(rz_flags[2], wa3, eff_mode);
  end

endmodule

//--- design/banked_regfile_top.sv
`timescale 1ns/1ns

module banked_regfile_top #(
  parameter int DATA_W = 32
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Core side
  input  regbank_pkg::cpu_mode_e               mode,
  input  logic                                 swi,
  input  logic [2:0]                           rz_flags,
  input  logic [regbank_pkg::ARCH_AW-1:0]      ra1,
  input  logic [regbank_pkg::ARCH_AW-1:0]      ra2,
  input  logic [regbank_pkg::ARCH_AW-1:0]      wa3,
  input  logic                                 we3,
  input  logic [DATA_W-1:0]                    wd3,
  output logic [DATA_W-1:0]                    rd1,
  output logic [DATA_W-1:0]                    rd2,
  // Debug Wishbone
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [regbank_pkg::PHYS_AW-1:0]      wb_adr,
  input  logic [DATA_W-1:0]                    wb_dat_i,
  output logic [DATA_W-1:0]                    wb_dat_o,
  output logic                                 wb_ack
);

  logic [regbank_pkg::NUM_PHYS-1:0] sel1, sel2, sel3;   // Decoded selects
  logic                             wr_en;
  logic [regbank_pkg::NUM_PHYS-1:0] wr_sel;
  logic [DATA_W-1:0]                wr_data;
  logic                             dbg_wreq, dbg_wgnt;
  logic [regbank_pkg::NUM_PHYS-1:0] dbg_wsel;
  logic [DATA_W-1:0]                dbg_wdata, dbg_rdata;
  logic [regbank_pkg::PHYS_AW-1:0]  dbg_ridx;

  bank_addr_decode u_decode (
    .mode(mode), .swi(swi), .rz_flags(rz_flags),
    .ra1(ra1), .ra2(ra2), .wa3(wa3),
    .sel1(sel1), .sel2(sel2), .sel3(sel3)
  );

  phys_reg_array #(.DATA_W(DATA_W)) u_array (
    .clk(clk), .rst_n(rst_n),
    .sel1(sel1), .sel2(sel2), .rd1(rd1), .rd2(rd2),
    .dbg_ridx(dbg_ridx), .dbg_rdata(dbg_rdata),
    .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data)
  );

  write_port_arbiter #(.DATA_W(DATA_W)) u_arb (
    .core_we(we3), .core_sel(sel3), .core_data(wd3),
    .dbg_wreq(dbg_wreq), .dbg_wsel(dbg_wsel), .dbg_wdata(dbg_wdata), .dbg_wgnt(dbg_wgnt),
    .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data)
  );

  wb_debug_slave #(.DATA_W(DATA_W)) u_dbg (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
    .dbg_wreq(dbg_wreq), .dbg_wsel(dbg_wsel), .dbg_wdata(dbg_wdata),
    .dbg_ridx(dbg_ridx), .dbg_wgnt(dbg_wgnt), .dbg_rdata(dbg_rdata)
  );

endmodule

//--- design/phys_reg_array.sv
`timescale 1ns/1ns

module phys_reg_array #(
  parameter int DATA_W = 32
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [regbank_pkg::NUM_PHYS-1:0]     sel1,      // One-hot, empty reads zero
  input  logic [regbank_pkg::NUM_PHYS-1:0]     sel2,
  output logic [DATA_W-1:0]                    rd1,
  output logic [DATA_W-1:0]                    rd2,
  input  logic [regbank_pkg::PHYS_AW-1:0]      dbg_ridx,  // Physical number
  output logic [DATA_W-1:0]                    dbg_rdata,
  input  logic                                 wr_en,
  input  logic [regbank_pkg::NUM_PHYS-1:0]     wr_sel,
  input  logic [DATA_W-1:0]                    wr_data
);

  logic [DATA_W-1:0] regs [regbank_pkg::NUM_PHYS];

  // Write port, one-hot select
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < regbank_pkg::NUM_PHYS; i++)
        regs[i] <= '0;                             // All banks start at zero
    end else if (wr_en) begin
      for (int i = 0; i < regbank_pkg::NUM_PHYS; i++) begin
        if (wr_sel[i])
          regs[i] <= wr_data;
      end
    end
  end

  // Core reads, AND-OR over the selects
  always_comb begin
    rd1 = '0;
    rd2 = '0;
    for (int i = 0; i < regbank_pkg::NUM_PHYS; i++) begin
      rd1 = rd1 | (regs[i] & {DATA_W{sel1[i]}});
      rd2 = rd2 | (regs[i] & {DATA_W{sel2[i]}});
    end
  end

  // Debug read by index, no arbitration needed
  assign dbg_rdata = regs[dbg_ridx];

endmodule

//--- design/regbank_pkg.sv
package regbank_pkg;

  // Processor mode field, CPSR[4:0]
  typedef enum logic [4:0] {
    USR = 5'b10000,
    FIQ = 5'b10001,
    IRQ = 5'b10010,
    SVC = 5'b10011,
    ABT = 5'b10111,
    UND = 5'b11011,
    SYS = 5'b11111
  } cpu_mode_e;

  // Kind of access held by the debug slave
  typedef enum logic {
    DBG_READ  = 1'b0,
    DBG_WRITE = 1'b1
  } dbg_kind_e;

  // Physical register file geometry
  localparam int NUM_PHYS = 32;      // All banks plus Rz
  localparam int ARCH_AW  = 4;       // R0..R15 as seen by programs
  localparam int PHYS_AW  = 5;       // Index into the physical array

  // Shadow register for micro-ops
  localparam logic [PHYS_AW-1:0] RZ_PHYS = 5'd31;
  localparam logic [ARCH_AW-1:0] RZ_ARCH = 4'd15; // Only address that reaches Rz

  // First physical register of each R13/R14 bank
  localparam logic [PHYS_AW-1:0] SVC_BANK = 5'd16;  // R13_svc, R14_svc
  localparam logic [PHYS_AW-1:0] ABT_BANK = 5'd18;
  localparam logic [PHYS_AW-1:0] UND_BANK = 5'd20;
  localparam logic [PHYS_AW-1:0] IRQ_BANK = 5'd22;

  // FIQ banks R8..R14 as one block, R8_fiq at 24 up to R14_fiq at 30
  localparam logic [PHYS_AW-1:0] FIQ_BANK = 5'd24;

  // Arch addresses with a banked meaning
  localparam logic [ARCH_AW-1:0] ARCH_R8  = 4'd8;
  localparam logic [ARCH_AW-1:0] ARCH_R12 = 4'd12;
  localparam logic [ARCH_AW-1:0] ARCH_R14 = 4'd14;

endpackage

//--- design/wb_debug_slave.sv
`timescale 1ns/1ns

module wb_debug_slave #(
  parameter int DATA_W = 32
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Wishbone classic
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [regbank_pkg::PHYS_AW-1:0]      wb_adr,    // Physical number
  input  logic [DATA_W-1:0]                    wb_dat_i,
  output logic [DATA_W-1:0]                    wb_dat_o,
  output logic                                 wb_ack,
  // Register file side
  output logic                                 dbg_wreq,
  output logic [regbank_pkg::NUM_PHYS-1:0]     dbg_wsel,
  output logic [DATA_W-1:0]                    dbg_wdata,
  output logic [regbank_pkg::PHYS_AW-1:0]      dbg_ridx,
  input  logic                                 dbg_wgnt,
  input  logic [DATA_W-1:0]                    dbg_rdata
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,   // Read capture or write waiting on the port
    ACK
  } state_e;

  state_e                          state;
  regbank_pkg::dbg_kind_e          pending;
  logic [regbank_pkg::PHYS_AW-1:0] adr_q;   // Latched bus address
  logic [DATA_W-1:0]               dat_q;   // Latched write data

  // Control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      pending <= regbank_pkg::DBG_READ;
    end else begin
      case (state)
        IDLE: begin
          if (wb_cyc && wb_stb) begin   // Ack already low here
            state   <= WAIT_GNT;
            pending <= wb_we ? regbank_pkg::DBG_WRITE : regbank_pkg::DBG_READ;
          end
        end
        WAIT_GNT: begin
          // Reads always done in one cycle, writes wait for the core to go idle
          if (pending == regbank_pkg::DBG_READ || dbg_wgnt)
            state <= ACK;
        end
        ACK:     state <= IDLE;             // Single-cycle ack
        default: state <= IDLE;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (state == IDLE && wb_cyc && wb_stb) begin
      adr_q <= wb_adr;
      dat_q <= wb_dat_i;
    end
    if (state == WAIT_GNT && pending == regbank_pkg::DBG_READ)
      wb_dat_o <= dbg_rdata;                // Valid with ack
  end

  assign wb_ack = (state == ACK);

  // Write request held until granted
  assign dbg_wreq  = (state == WAIT_GNT) && (pending == regbank_pkg::DBG_WRITE);
  assign dbg_wsel  = regbank_pkg::NUM_PHYS'(1) << adr_q;  // Index to one-hot
  assign dbg_wdata = dat_q;
  assign dbg_ridx  = adr_q;

endmodule

//--- design/write_port_arbiter.sv
`timescale 1ns/1ns

module write_port_arbiter #(
  parameter int DATA_W = 32
) (
  // Core writeback
  input  logic                                 core_we,
  input  logic [regbank_pkg::NUM_PHYS-1:0]     core_sel,
  input  logic [DATA_W-1:0]                    core_data,
  // Debug slave request
  input  logic                                 dbg_wreq,
  input  logic [regbank_pkg::NUM_PHYS-1:0]     dbg_wsel,
  input  logic [DATA_W-1:0]                    dbg_wdata,
  output logic                                 dbg_wgnt,
  // Array write port
  output logic                                 wr_en,
  output logic [regbank_pkg::NUM_PHYS-1:0]     wr_sel,
  output logic [DATA_W-1:0]                    wr_data
);

  logic core_win;

  // Core never stalls, so it always takes the port
  assign core_win = core_we;

  // Debug only in a core-idle cycle; slave holds wreq until then
  assign dbg_wgnt = dbg_wreq & ~core_win;

  assign wr_en = core_win | dbg_wgnt;

  // Port mux
  always_comb begin
    if (core_win) begin
      wr_sel  = core_sel;
      wr_data = core_data;
    end else begin
      wr_sel  = dbg_wsel;   // Only acts when wr_en from dbg_wgnt
      wr_data = dbg_wdata;
    end
  end

endmodule

//--- verification/banked_regfile_tb.sv
`timescale 1ns/1ns

module banked_regfile_tb;

  localparam int DATA_W = 32;
  localparam int NONE   = regbank_pkg::NUM_PHYS;  // Target code for an empty select

  logic                            clk;
  logic                            rst_n;
  regbank_pkg::cpu_mode_e          mode;
  logic                            swi;
  logic [2:0]                      rz_flags;
  logic [regbank_pkg::ARCH_AW-1:0] ra1;
  logic [regbank_pkg::ARCH_AW-1:0] ra2;
  logic [regbank_pkg::ARCH_AW-1:0] wa3;
  logic                            we3;
  logic [DATA_W-1:0]               wd3;
  logic [DATA_W-1:0]               rd1;
  logic [DATA_W-1:0]               rd2;
  logic                            wb_cyc;
  logic                            wb_stb;
  logic                            wb_we;
  logic [regbank_pkg::PHYS_AW-1:0] wb_adr;
  logic [DATA_W-1:0]               wb_dat_i;
  logic [DATA_W-1:0]               wb_dat_o;
  logic                            wb_ack;

  logic [DATA_W-1:0] model [regbank_pkg::NUM_PHYS];  // Expected physical contents
  string             lines[$];                       // Case lines without comment lines
  integer            seed;
  int                cycles;
  int                limit;                          // 0 until the cases are counted

  tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

  banked_regfile_top #(.DATA_W(DATA_W)) UUT (
    .clk(clk), .rst_n(rst_n),
    .mode(mode), .swi(swi), .rz_flags(rz_flags),
    .ra1(ra1), .ra2(ra2), .wa3(wa3), .we3(we3), .wd3(wd3), .rd1(rd1), .rd2(rd2),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
  );

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Read-back against the model entry of the decoded target
  task automatic check_mode_sel(input string name, input int target,
                                input logic [DATA_W-1:0] act);
    logic [DATA_W-1:0] exp;
    exp = (target < NONE) ? model[target] : '0;  // Empty select reads zero
    if (act !== exp) begin
      $display("[ERROR] %s: phys %0d expected %h, actual %h", name, target, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: ack expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Preload value that carries every address bit in two bytes
  function automatic logic [DATA_W-1:0] fill_word(input int p);
    return 32'hc0de_0000 + 32'(p) * 32'h0000_0101;
  endfunction

  task automatic core_write(input regbank_pkg::cpu_mode_e md, input logic sw,
                            input logic [2:0] rz, input logic [3:0] addr,
                            input logic [DATA_W-1:0] data, input int target);
    mode     = md;
    swi      = sw;
    rz_flags = rz;
    wa3      = addr;
    wd3      = data;
    we3      = 1'b1;
    @(negedge clk);             // Lands at the rising edge in between
    we3 = 1'b0;
    if (target < NONE)
      model[target] = data;
  endtask

  task automatic core_read(input string name, input regbank_pkg::cpu_mode_e md,
                           input logic sw, input logic [2:0] rz, input logic [3:0] a1,
                           input logic [3:0] a2, input int t1, input int t2);
    mode     = md;
    swi      = sw;
    rz_flags = rz;
    ra1      = a1;
    ra2      = a2;
    @(negedge clk);             // Inputs settled a half cycle
    check_mode_sel(name, t1, rd1);
    check_mode_sel(name, t2, rd2);
  endtask

  // One Wishbone access with the core idle and ack due one cycle after the first edge
  task automatic debug_access(input string name, input regbank_pkg::dbg_kind_e kind,
                              input logic [4:0] adr, input logic [DATA_W-1:0] data);
    we3      = 1'b0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = (kind == regbank_pkg::DBG_WRITE);
    wb_adr   = adr;
    wb_dat_i = data;
    @(negedge clk);
    check_ack(name, 1'b0, wb_ack);   // Request seen but no ack yet
    @(negedge clk);
    check_ack(name, 1'b1, wb_ack);
    if (kind == regbank_pkg::DBG_READ)
      check_word(name, model[adr], wb_dat_o);
    else
      model[adr] = data;
    @(negedge clk);                  // Master saw ack on the last edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    check_ack(name, 1'b0, wb_ack);   // Single-cycle pulse
  endtask

  // Debug write held off while the core writes for ncyc cycles
  task automatic collide(input string name, input regbank_pkg::cpu_mode_e md,
                         input logic [4:0] dadr, input logic [3:0] wa,
                         input int ncyc, input int target);
    logic [DATA_W-1:0] dbg_data;
    logic [DATA_W-1:0] core_data;
    dbg_data  = $random(seed);
    core_data = '0;
    mode      = md;
    swi       = 1'b0;
    rz_flags  = 3'b000;
    ra1       = wa;
    wa3       = wa;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = 1'b1;
    wb_adr    = dadr;
    wb_dat_i  = dbg_data;
    for (int i = 0; i < ncyc; i++) begin
      core_data = $random(seed);
      wd3       = core_data;
      we3       = 1'b1;
      @(negedge clk);
      check_ack(name, 1'b0, wb_ack);      // Debug waits on the core
      check_word(name, core_data, rd1);   // Core value wins at its edge
    end
    we3 = 1'b0;
    do begin
      @(negedge clk);
    end while (!wb_ack);                  // Ack may come after any number of cycles
    if (ncyc > 0 && target < NONE)
      model[target] = core_data;
    model[dadr] = dbg_data;               // Debug lands after the core
    check_mode_sel(name, target, rd1);
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    check_ack(name, 1'b0, wb_ack);
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: run went past %0d clock cycles", limit);
      abort_run();
    end
  end

  initial begin
    int                     fd;
    int                     n;
    string                  line;
    string                  name;
    string                  kind;
    logic [31:0]            f_mode, f_swi, f_rz, f_ra1, f_ra2, f_wa, f_data, f_exp;
    regbank_pkg::cpu_mode_e md;
    seed     = 57;
    cycles   = 0;
    limit    = 0;
    mode     = regbank_pkg::USR;
    swi      = 1'b0;
    rz_flags = 3'b000;
    ra1      = '0;
    ra2      = '0;
    wa3      = '0;
    we3      = 1'b0;
    wd3      = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    foreach (model[i])
      model[i] = '0;                 // Array clears on reset
    fd = $fopen("verification/regfile_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file");
      abort_run();
    end
    while ($fgets(line, fd)) begin
      if (line.len() > 1 && line.substr(0, 0) != "#")
        lines.push_back(line);
    end
    $fclose(fd);
    // Cases, reset check with preload, and final sweep
    limit = 10 * (lines.size() + 3 * regbank_pkg::NUM_PHYS) + 100;
    @(posedge rst_n);
    @(negedge clk);
    // Reset contents, then a distinct value in every register so empty selects read apart
    for (int p = 0; p < regbank_pkg::NUM_PHYS; p++) begin
      debug_access($sformatf("reset_%0d", p), regbank_pkg::DBG_READ, 5'(p), '0);
      debug_access($sformatf("fill_%0d", p), regbank_pkg::DBG_WRITE, 5'(p), fill_word(p));
    end
    foreach (lines[i]) begin
      n = $sscanf(lines[i], "%s %s %h %h %h %h %h %h %h %h", name, kind,
                  f_mode, f_swi, f_rz, f_ra1, f_ra2, f_wa, f_data, f_exp);
      if (n != 10) begin
        $display("Case line %0d is malformed", i);
        abort_run();
      end
      md = regbank_pkg::cpu_mode_e'(f_mode[4:0]);
      if (kind == "cw")
        core_write(md, f_swi[0], f_rz[2:0], f_wa[3:0], f_data, int'(f_exp));
      else if (kind == "cr")
        core_read(name, md, f_swi[0], f_rz[2:0], f_ra1[3:0], f_ra2[3:0],
                  int'(f_exp), int'(f_data));
      else if (kind == "dw")
        debug_access(name, regbank_pkg::DBG_WRITE, f_wa[4:0], f_data);
      else if (kind == "dr")
        debug_access(name, regbank_pkg::DBG_READ, f_wa[4:0], '0);
      else if (kind == "cl")
        collide(name, md, f_ra1[4:0], f_wa[3:0], int'(f_data), int'(f_exp));
      else begin
        $display("Case %s has an unknown kind %s", name, kind);
        abort_run();
      end
    end
    // Every physical register against the model to catch stray writes
    for (int p = 0; p < regbank_pkg::NUM_PHYS; p++)
      debug_access($sformatf("sweep_%0d", p), regbank_pkg::DBG_READ, 5'(p), '0);
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verification/regfile_cases.txt
# name kind mode swi rz ra1 ra2 wa data expect; numbers hex, target 20 is no register
# cw: data to phys expect; cr: rd1/rd2 at phys expect/data; dr dw: wa is phys; cl: ra1 dbg phys
w13_usr  cw 10 0 0 0 0 d 0000d010 d
w14_usr  cw 10 0 0 0 0 e 0000e010 e
w13_svc  cw 13 0 0 0 0 d 0000d013 10
w14_svc  cw 13 0 0 0 0 e 0000e013 11
w13_abt  cw 17 0 0 0 0 d 0000d017 12
w14_abt  cw 17 0 0 0 0 e 0000e017 13
w13_und  cw 1b 0 0 0 0 d 0000d01b 14
w14_und  cw 1b 0 0 0 0 e 0000e01b 15
w13_irq  cw 12 0 0 0 0 d 0000d012 16
w14_irq  cw 12 0 0 0 0 e 0000e012 17
w13_fiq  cw 11 0 0 0 0 d 0000d011 1d
w14_fiq  cw 11 0 0 0 0 e 0000e011 1e
r_usr    cr 10 0 0 d e 0 e d
r_sys    cr 1f 0 0 d e 0 e d
r_svc    cr 13 0 0 d e 0 11 10
r_abt    cr 17 0 0 d e 0 13 12
r_und    cr 1b 0 0 d e 0 15 14
r_irq    cr 12 0 0 d e 0 17 16
r_fiq    cr 11 0 0 d e 0 1e 1d
dr_p13   dr 10 0 0 0 0 d 0 0
dr_p16   dr 10 0 0 0 0 10 0 0
w8_usr   cw 10 0 0 0 0 8 00080010 8
w12_usr  cw 10 0 0 0 0 c 000c0010 c
w8_fiq   cw 11 0 0 0 0 8 00080011 18
w12_fiq  cw 11 0 0 0 0 c 000c0011 1c
r8_usr   cr 10 0 0 8 c 0 c 8
r8_fiq   cr 11 0 0 8 c 0 1c 18
w0_fiq   cw 11 0 0 0 0 0 00000011 0
w15_svc  cw 13 0 0 0 0 f 000f0013 f
r0_irq   cr 12 0 0 0 f 0 f 0
r13_swi  cr 10 1 0 d e 0 11 10
w13_swi  cw 10 1 0 0 0 d 5a5a0013 10
wz       cw 10 0 4 0 0 f 000f001f 1f
wz_bad   cw 10 0 4 0 0 3 0003001f 20
rz_read  cr 10 0 3 f 3 0 20 1f
rbad     cr 00 0 0 d e 0 20 20
wbad     cw 00 0 0 0 0 e 0000e000 20
r0bad    cr 00 0 0 0 d 0 20 0
dw_p9    dw 10 0 0 0 0 9 00090009 9
r9_usr   cr 10 0 0 9 9 0 9 9
cl_same  cl 10 0 0 5 0 5 3 5
cl_diff  cl 13 0 0 1a 0 d 4 10

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_NS = 4;  // 8 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  // Reset low over the first 4 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;             // Released just after the 4th edge
  end

endmodule
